// File: logic/isa_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction set definitions: field widths, opcodes,
// function codes, ALU operations and the decoded form
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isa_pkg;

    // Register and memory word width
    localparam int word_width    = 32;
    localparam int num_regs      = 32;

    // Instruction field widths shared by the R, I and J formats
    localparam int opcode_width  = 6;
    localparam int reg_idx_width = 5;
    localparam int shamt_width   = 5;
    localparam int funct_width   = 6;
    localparam int imm_width     = 16;
    localparam int target_width  = 26;

    // Function codes under opcode 0 and opcode 7
    localparam logic [funct_width-1:0] funct_add = 6'd0;
    localparam logic [funct_width-1:0] funct_sub = 6'd1;
    localparam logic [funct_width-1:0] funct_sll = 6'd0;
    localparam logic [funct_width-1:0] funct_srl = 6'd1;

    typedef logic [reg_idx_width-1:0] reg_idx_t;

    typedef enum logic [opcode_width-1:0] {
        opc_rtype_arith = 6'd0,
        opc_addi        = 6'd1,
        opc_and         = 6'd3,
        opc_or          = 6'd4,
        opc_andi        = 6'd5,
        opc_ori         = 6'd6,
        opc_shift       = 6'd7,
        opc_lw          = 6'd8,
        opc_sw          = 6'd9,
        opc_beq         = 6'd10,
        opc_bne         = 6'd11,
        opc_j           = 6'd16,
        opc_slt         = 6'd19,
        opc_slti        = 6'd20
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_sll,
        alu_srl,
        alu_slt
    } alu_op_t;

    // Everything the datapath needs from one instruction
    typedef struct packed {
        alu_op_t                 alu_op;
        reg_idx_t                rs;
        reg_idx_t                rt;
        reg_idx_t                rd;
        logic [word_width-1:0]   imm;
        logic [shamt_width-1:0]  shamt;
        logic                    use_imm;
        logic                    reg_write;
        logic                    mem_read;
        logic                    mem_write;
        logic                    branch_eq;
        logic                    branch_ne;
        logic                    jump;
        logic [target_width-1:0] target;
    } decoded_t;

endpackage

// File: logic/cpu_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Machine definitions: memory size, word types, the load
// stream word and the control states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpu_pkg;

    // Both memories hold this many words
    localparam int mem_depth  = 256;
    localparam int addr_width = $clog2(mem_depth);

    typedef logic [addr_width-1:0]          addr_t;
    typedef logic [isa_pkg::word_width-1:0] instr_word_t;
    typedef logic [isa_pkg::word_width-1:0] data_word_t;

    // One beat of the load stream
    // to_data picks the data memory, otherwise the word is an instruction
    typedef struct packed {
        logic       valid;
        logic       to_data;
        data_word_t word;
    } load_word_t;

    typedef enum logic [2:0] {
        s_load,
        s_fetch,
        s_decode,
        s_execute,
        s_writeback,
        s_done
    } cpu_state_t;

endpackage

// File: logic/word_memory.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port synchronous memory of 256 words
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module word_memory #(
    parameter type payload_t = logic [31:0]
) (
    input  logic       clk,
    input  logic       we,
    input  logic [7:0] addr,
    input  payload_t   wdata,
    output payload_t   rdata
);

    payload_t mem [256];

    // Write on the edge and register the read
    // A read of the address being written returns the old word
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: logic/address_counter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load pointers for both memories, the program counter
// and the instruction count latched at start
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module address_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::cpu_state_t state,
    input  cpu_pkg::load_word_t load,
    input  logic                start,
    input  cpu_pkg::addr_t      next_pc,
    output cpu_pkg::addr_t      instr_load_addr,
    output cpu_pkg::addr_t      data_load_addr,
    output cpu_pkg::addr_t      pc,
    output cpu_pkg::addr_t      instr_count
);

    logic loading;

    // Words are only taken while the machine sits in the load state
    assign loading = (state == cpu_pkg::s_load);

    // Each pointer steps past the word just written to its memory
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_load_addr <= '0;
            data_load_addr  <= '0;
        end else if (loading && load.valid) begin
            if (load.to_data) begin
                data_load_addr <= data_load_addr + 1'b1;
            end else begin
                instr_load_addr <= instr_load_addr + 1'b1;
            end
        end
    end

    // The instruction pointer at start marks the end of the program
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            instr_count <= '0;
        end else if (loading && start) begin
            pc          <= '0;
            instr_count <= instr_load_addr;
        end else if (state == cpu_pkg::s_writeback) begin
            pc <= next_pc;
        end
    end

endmodule

// File: logic/instr_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational instruction decoder
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module instr_decoder (
    input  cpu_pkg::instr_word_t instr,
    output isa_pkg::decoded_t    dec
);

    localparam int ext_width = isa_pkg::word_width - isa_pkg::imm_width;

    isa_pkg::opcode_t                  opcode;
    logic [isa_pkg::funct_width-1:0]   funct;
    logic [isa_pkg::imm_width-1:0]     imm16;

    assign opcode = isa_pkg::opcode_t'(instr[31:26]);
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];

    always_comb begin
        // Unknown opcodes fall through as a no-op with every flag low
        dec        = '0;
        dec.rs     = instr[25:21];
        dec.rt     = instr[20:16];
        dec.rd     = instr[15:11];
        dec.shamt  = instr[10:6];
        dec.target = instr[25:0];
        dec.imm    = {{ext_width{imm16[isa_pkg::imm_width-1]}}, imm16};

        case (opcode)
            isa_pkg::opc_rtype_arith: begin
                dec.reg_write = (funct == isa_pkg::funct_add) || (funct == isa_pkg::funct_sub);
                dec.alu_op    = (funct == isa_pkg::funct_sub) ? isa_pkg::alu_sub : isa_pkg::alu_add;
            end
            isa_pkg::opc_shift: begin
                dec.reg_write = (funct == isa_pkg::funct_sll) || (funct == isa_pkg::funct_srl);
                dec.alu_op    = (funct == isa_pkg::funct_srl) ? isa_pkg::alu_srl : isa_pkg::alu_sll;
            end
            isa_pkg::opc_and: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = isa_pkg::alu_and;
            end
            isa_pkg::opc_or: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = isa_pkg::alu_or;
            end
            isa_pkg::opc_slt: begin
                dec.reg_write = 1'b1;
                dec.alu_op    = isa_pkg::alu_slt;
            end
            isa_pkg::opc_addi, isa_pkg::opc_slti: begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.alu_op    = (opcode == isa_pkg::opc_slti) ? isa_pkg::alu_slt : isa_pkg::alu_add;
            end
            isa_pkg::opc_andi, isa_pkg::opc_ori: begin
                // Logic immediates are zero-extended
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.imm       = {{ext_width{1'b0}}, imm16};
                dec.alu_op    = (opcode == isa_pkg::opc_ori) ? isa_pkg::alu_or : isa_pkg::alu_and;
            end
            isa_pkg::opc_lw: begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.mem_read  = 1'b1;
            end
            isa_pkg::opc_sw: begin
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            // Branches compare rs with rt, the offset stays in imm
            isa_pkg::opc_beq: dec.branch_eq = 1'b1;
            isa_pkg::opc_bne: dec.branch_ne = 1'b1;
            isa_pkg::opc_j:   dec.jump      = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: logic/alu.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU with add, sub, logic, shifts, signed compare and an
// operand equality flag for branches
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu (
    input  isa_pkg::alu_op_t                op,
    input  logic [isa_pkg::word_width-1:0]  a,
    input  logic [isa_pkg::word_width-1:0]  b,
    input  logic [isa_pkg::shamt_width-1:0] shamt,
    output logic [isa_pkg::word_width-1:0]  result,
    output logic                            equal
);

    logic less;

    // Operands are two's complement for the compare
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            isa_pkg::alu_add: result = a + b;
            isa_pkg::alu_sub: result = a - b;
            isa_pkg::alu_and: result = a & b;
            isa_pkg::alu_or:  result = a | b;
            // Shifts move the rs operand by the instruction's shift field
            isa_pkg::alu_sll: result = a << shamt;
            isa_pkg::alu_srl: result = a >> shamt;
            isa_pkg::alu_slt: result = {{(isa_pkg::word_width - 1){1'b0}}, less};
            default:          result = '0;
        endcase
    end

    // Used by beq and bne, where b carries rt
    assign equal = (a == b);

endmodule

// File: logic/reg_file.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file, two read ports and one write port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module reg_file (
    input  logic                           clk,
    input  logic                           we,
    input  isa_pkg::reg_idx_t              waddr,
    input  logic [isa_pkg::word_width-1:0] wdata,
    input  isa_pkg::reg_idx_t              raddr_a,
    input  isa_pkg::reg_idx_t              raddr_b,
    output logic [isa_pkg::word_width-1:0] rdata_a,
    output logic [isa_pkg::word_width-1:0] rdata_b
);

    // Register 0 has no storage behind it
    logic [isa_pkg::word_width-1:0] regs [1:isa_pkg::num_regs-1];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// File: logic/cpu_control.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control FSM: load, fetch, decode, execute, writeback, done
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cpu_control (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                program_end,
    output cpu_pkg::cpu_state_t state,
    output logic                done
);

    cpu_pkg::cpu_state_t state_next;

    // One state per cycle once running, so every instruction takes four cycles
    always_comb begin
        state_next = state;
        case (state)
            cpu_pkg::s_load: begin
                if (start) begin
                    state_next = cpu_pkg::s_fetch;
                end
            end
            cpu_pkg::s_fetch:   state_next = cpu_pkg::s_decode;
            cpu_pkg::s_decode:  state_next = cpu_pkg::s_execute;
            cpu_pkg::s_execute: state_next = cpu_pkg::s_writeback;
            cpu_pkg::s_writeback: begin
                // The new pc meeting the instruction count ends the run
                state_next = program_end ? cpu_pkg::s_done : cpu_pkg::s_fetch;
            end
            // Only reset leaves the done state
            cpu_pkg::s_done: state_next = cpu_pkg::s_done;
            default:         state_next = cpu_pkg::s_load;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cpu_pkg::s_load;
        end else begin
            state <= state_next;
        end
    end

    // Set on the same edge that enters s_done, so done tracks that state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if ((state == cpu_pkg::s_writeback) && program_end) begin
            done <= 1'b1;
        end
    end

endmodule

// File: logic/cpu_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Processor top level: control, counters, memories, decode,
// register file, ALU, next pc and memory address muxes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cpu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::load_word_t load,
    input  logic                start,
    output logic                done,
    input  cpu_pkg::addr_t      dump_addr,
    output cpu_pkg::data_word_t dump_data
);

    localparam int aw = cpu_pkg::addr_width;

    cpu_pkg::cpu_state_t  state;
    cpu_pkg::addr_t       instr_load_addr, data_load_addr, pc, instr_count;
    cpu_pkg::addr_t       next_pc, pc_plus_one, imem_addr, dmem_addr;
    cpu_pkg::instr_word_t imem_rdata, ir;
    cpu_pkg::data_word_t  dmem_rdata, dmem_wdata, rdata_a, rdata_b;
    cpu_pkg::data_word_t  alu_b, alu_result, reg_wdata;
    isa_pkg::decoded_t    dec;
    isa_pkg::reg_idx_t    reg_waddr;
    logic                 loading, imem_we, dmem_we, reg_we, equal, branch_taken;
    logic                 program_end;

    assign loading = (state == cpu_pkg::s_load);

    cpu_control u_control (
        .clk(clk), .rst_n(rst_n), .start(start), .program_end(program_end),
        .state(state), .done(done)
    );

    address_counter u_counter (
        .clk(clk), .rst_n(rst_n), .state(state), .load(load), .start(start),
        .next_pc(next_pc), .instr_load_addr(instr_load_addr),
        .data_load_addr(data_load_addr), .pc(pc), .instr_count(instr_count)
    );

    // Instruction memory is written while loading and read at pc otherwise
    assign imem_we   = loading && load.valid && !load.to_data;
    assign imem_addr = loading ? instr_load_addr : pc;

    word_memory #(.payload_t(cpu_pkg::instr_word_t)) u_imem (
        .clk(clk), .we(imem_we), .addr(imem_addr),
        .wdata(cpu_pkg::instr_word_t'(load.word)), .rdata(imem_rdata)
    );

    // The word read in fetch arrives in decode and is held until the next decode
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::s_decode) begin
            ir <= imem_rdata;
        end
    end

    instr_decoder u_decoder (.instr(ir), .dec(dec));

    // Immediate forms and lw write rt, register forms write rd
    assign reg_waddr = dec.use_imm ? dec.rt : dec.rd;
    assign reg_wdata = dec.mem_read ? dmem_rdata : alu_result;
    assign reg_we    = (state == cpu_pkg::s_writeback) && dec.reg_write;

    reg_file u_regs (
        .clk(clk), .we(reg_we), .waddr(reg_waddr), .wdata(reg_wdata),
        .raddr_a(dec.rs), .raddr_b(dec.rt), .rdata_a(rdata_a), .rdata_b(rdata_b)
    );

    assign alu_b = dec.use_imm ? dec.imm : rdata_b;

    alu u_alu (
        .op(dec.alu_op), .a(rdata_a), .b(alu_b), .shamt(dec.shamt),
        .result(alu_result), .equal(equal)
    );

    // Data memory address follows the phase: load pointer, rs plus imm, read-out
    always_comb begin
        case (state)
            cpu_pkg::s_load: dmem_addr = data_load_addr;
            cpu_pkg::s_done: dmem_addr = dump_addr;
            default:         dmem_addr = alu_result[aw-1:0];
        endcase
    end

    // sw stores rt in execute, lw data is ready for writeback a cycle later
    assign dmem_we    = (loading && load.valid && load.to_data)
                     || ((state == cpu_pkg::s_execute) && dec.mem_write);
    assign dmem_wdata = loading ? load.word : rdata_b;

    word_memory #(.payload_t(cpu_pkg::data_word_t)) u_dmem (
        .clk(clk), .we(dmem_we), .addr(dmem_addr),
        .wdata(dmem_wdata), .rdata(dmem_rdata)
    );

    assign dump_data = dmem_rdata;

    // Branch offsets count words from the instruction after the branch
    assign pc_plus_one  = pc + 1'b1;
    assign branch_taken = (dec.branch_eq && equal) || (dec.branch_ne && !equal);

    always_comb begin
        if (dec.jump) begin
            next_pc = dec.target[aw-1:0];
        end else if (branch_taken) begin
            next_pc = pc_plus_one + dec.imm[aw-1:0];
        end else begin
            next_pc = pc_plus_one;
        end
    end

    // Only sampled by the FSM in writeback
    assign program_end = (next_pc == instr_count);

endmodule

// File: dv/tb_cpu.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Processor testbench: stim file reader, load stream with
// gaps, start-to-done timing and data memory read-out checks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_cpu;

    logic                clk;
    logic                rst_n;
    cpu_pkg::load_word_t load;
    logic                start;
    logic                done;
    cpu_pkg::addr_t      dump_addr;
    cpu_pkg::data_word_t dump_data;

    // Contents of the stim file, load words kept in file order
    logic [31:0]    load_words[$];
    logic           load_to_data[$];
    cpu_pkg::addr_t exp_addr[$];
    logic [31:0]    exp_value[$];
    int             exec_count = 0;

    int     cycle_count = 0;
    int     cycle_limit = 10000;
    integer seed = 32'hbdf2;

    cpu_top dut0 (
        .clk(clk), .rst_n(rst_n), .load(load), .start(start), .done(done),
        .dump_addr(dump_addr), .dump_data(dump_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                name, expected, actual));
        end
    endtask

    // Guards against a run that never raises done or stalls in read-out
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run("Timeout: the run did not finish within the cycle limit");
        end
    end

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    // Each line starts with a tag, lines tagged # are comments
    task automatic read_stim();
        int          fd;
        int          code;
        logic [63:0] tag;
        logic [31:0] addr;
        logic [31:0] value;
        fd = $fopen("dv/cpu_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stim file dv/cpu_stim.txt");
        end
        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            if (tag == "#") begin
                skip_line(fd);
            end else if (tag == "i" || tag == "d") begin
                code = $fscanf(fd, "%h", value);
                load_words.push_back(value);
                load_to_data.push_back(tag == "d");
            end else if (tag == "e") begin
                code = $fscanf(fd, "%h %h", addr, value);
                exp_addr.push_back(addr[7:0]);
                exp_value.push_back(value);
            end else if (tag == "n") begin
                code = $fscanf(fd, "%d", exec_count);
            end else begin
                abort_run("The stim file holds a line with an unknown tag");
            end
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
        if (load_words.size() == 0 || exp_addr.size() == 0 || exec_count == 0) begin
            abort_run("The stim file lacks program words, expected values or a count");
        end
    endtask

    task automatic stream_words();
        int k;
        int gap;
        for (k = 0; k < load_words.size(); k++) begin
            gap = $unsigned($random(seed)) % 4;
            // Junk with valid low must leave both load pointers alone
            repeat (gap) begin
                @(posedge clk);
                load.valid   <= 1'b0;
                load.to_data <= ~load_to_data[k];
                load.word    <= 32'hbad00000 | k;
            end
            @(posedge clk);
            load.valid   <= 1'b1;
            load.to_data <= load_to_data[k];
            load.word    <= load_words[k];
            @(negedge clk);
            check_value("done low while loading", 32'd0, {31'd0, done});
        end
        @(posedge clk);
        load.valid <= 1'b0;
    endtask

    // Counts rising edges from the edge that drives start until done is seen
    task automatic start_and_time();
        int cycles;
        @(negedge clk);
        check_value("done low before start", 32'd0, {31'd0, done});
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (done !== 1'b1) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        // One cycle to reach fetch, then four per executed instruction
        check_value("cycles from start to done", 4 * exec_count + 1, cycles);
    endtask

    task automatic read_back();
        int i;
        for (i = 0; i < exp_addr.size(); i++) begin
            @(posedge clk);
            dump_addr <= exp_addr[i];
            // The read is registered, so the word shows one edge later
            @(posedge clk);
            @(negedge clk);
            check_value("done held during read-out", 32'd1, {31'd0, done});
            check_value($sformatf("dmem[%0d]", exp_addr[i]), exp_value[i], dump_data);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        load      = '0;
        start     = 1'b0;
        dump_addr = '0;
        read_stim();
        // Worst case load is four cycles per word, read-out two per address
        cycle_limit = 4 * exec_count + 4 * load_words.size() + 2 * exp_addr.size() + 100;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        stream_words();
        start_and_time();
        read_back();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: all.f
logic/isa_pkg.sv
logic/cpu_pkg.sv
logic/word_memory.sv
logic/address_counter.sv
logic/instr_decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/cpu_control.sv
logic/cpu_top.sv
dv/tb_cpu.sv

// File: dv/cpu_stim.txt
# tag i instruction word, d data word, e data memory address and expected word (hex)
# tag n instructions executed; i and d words load in order at their own addresses
n 39
# lw r1..r3, then add sub and or sll srl addi
i 20010000
i 20020001
i 20030002
i 00222000
i 00222801
i 0c623000
i 10223800
i 1c204100
i 1c404f01
i 042afffd
# data words 0..2 are operands
d 00000007
d fffffff0
d 12345678
# andi ori slt slt slti, write attempt to r0, stores of results
i 144bff00
i 182c8000
i 4c416800
i 4c227000
i 504fffff
i 04200005
i 24040008
i 24050009
i 2406000a
i 2407000b
i 2408000c
i 2409000d
i 240a000e
i 240b000f
i 240c0010
i 240d0011
# data words 3..5 are markers that skipped stores would overwrite
d a5a5a5a5
d 5a5a5a5a
d 0f0f0f0f
i 240e0012
i 240f0013
i 24000014
i 20100008
i 24100015
# beq not taken, beq taken, bne not taken, bne taken, j over one store
i 28220001
i 24010016
i 28210001
i 24020003
i 2c210001
i 24020017
i 2c220001
i 24010004
i 40000029
i 24010005
i 24030018
e 03 a5a5a5a5
e 04 5a5a5a5a
e 05 0f0f0f0f
e 08 fffffff7
e 09 00000017
e 0a 12345670
e 0b fffffff7
e 0c 00000070
e 0d 0000000f
e 0e 00000004
e 0f 0000ff00
e 10 00008007
e 11 00000001
e 12 00000000
e 13 00000001
e 14 00000000
e 15 fffffff7
e 16 00000007
e 17 fffffff0
e 18 12345678
